// ==== hdl/hdmi_defines.svh ====
`ifndef HDMI_DEFINES_SVH
`define HDMI_DEFINES_SVH

// Local register bus
`define HDMI_LB_ADDR_W 8
`define HDMI_LB_DATA_W 32

// System memory port, word addressed
`define HDMI_MEM_ADDR_W 27
`define HDMI_MEM_DATA_W 32

// Horizontal raster, in pixels
`define HDMI_H_ACTIVE 8
`define HDMI_H_FP 2
`define HDMI_H_SYNC 2
`define HDMI_H_BP 2

// Vertical raster, in lines
`define HDMI_V_ACTIVE 4
`define HDMI_V_FP 1
`define HDMI_V_SYNC 1
`define HDMI_V_BP 1

// 0 gives active low HSYNC/VSYNC
`define HDMI_SYNC_ACTIVE_HIGH 0

`define HDMI_FIFO_DEPTH 16

// Read data for addresses outside the register map
`define HDMI_UNMAPPED_RD_VAL 32'hdeadbabe

`endif

// ==== hdl/hdmi_bus_pkg.sv ====
`default_nettype none

`include "hdmi_defines.svh"

package hdmi_bus_pkg;

  // Host side register bus
  typedef logic [`HDMI_LB_ADDR_W-1:0] lb_addr_t;
  typedef logic [`HDMI_LB_DATA_W-1:0] lb_data_t;

  // External memory, one word per address
  typedef logic [`HDMI_MEM_ADDR_W-1:0] mem_addr_t;
  typedef logic [`HDMI_MEM_DATA_W-1:0] mem_data_t;

  // Register map byte offsets
  typedef enum lb_addr_t {
    CONFIG     = 8'h00,
    STATUS     = 8'h04,
    FIFO_OCC   = 8'h08,
    FB_BASE    = 8'h0c,
    FB_WR_ADDR = 8'h10,
    FB_WR_DATA = 8'h14
  } reg_offset_e;

endpackage

`default_nettype wire

// ==== hdl/hdmi_video_pkg.sv ====
`default_nettype none

`include "hdmi_defines.svh"

package hdmi_video_pkg;

  // RGB888, low 24 bits of a memory word
  typedef logic [23:0] pixel_t;

  // Occupancy needs one extra code for a full FIFO
  typedef logic [$clog2(`HDMI_FIFO_DEPTH+1)-1:0] fifo_cnt_t;

  // Phase counters, sized for a whole line or frame
  typedef logic [$clog2(`HDMI_H_ACTIVE+`HDMI_H_FP+`HDMI_H_SYNC+`HDMI_H_BP)-1:0] h_cnt_t;
  typedef logic [$clog2(`HDMI_V_ACTIVE+`HDMI_V_FP+`HDMI_V_SYNC+`HDMI_V_BP)-1:0] v_cnt_t;

  // Shared by the horizontal and vertical FSMs
  typedef enum logic [1:0] {ACTIVE, FRONT, SYNC, BACK} timing_phase_e;

endpackage

`default_nettype wire

// ==== hdl/mem_req_if.sv ====
`default_nettype none
`timescale 1ns/100ps

// One requester's path to the memory arbiter
interface mem_req_if;

  logic                    valid;
  logic                    ready;
  logic                    we;
  hdmi_bus_pkg::mem_addr_t addr;
  hdmi_bus_pkg::mem_data_t wdata;

  // Payload held stable from valid up to the handshake
  modport requester (output valid, output we, output addr, output wdata, input ready);

  // Ready only ever reaches the granted side
  modport arbiter (input valid, input we, input addr, input wdata, output ready);

endinterface

`default_nettype wire

// ==== hdl/hdmi_regfile.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "hdmi_defines.svh"

module hdmi_regfile (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      lb_wr_en,
  input  logic                      lb_rd_en,
  input  hdmi_bus_pkg::lb_addr_t    lb_addr,
  input  hdmi_bus_pkg::lb_data_t    lb_wr_data,
  output logic                      lb_wr_valid,
  output logic                      lb_rd_valid,
  output hdmi_bus_pkg::lb_data_t    lb_rd_data,
  input  hdmi_video_pkg::fifo_cnt_t fifo_count,
  input  logic                      underflow,
  output logic                      underflow_clr,
  output logic                      fetch_en,
  output logic                      drvr_en,
  output hdmi_bus_pkg::mem_addr_t   fb_base,
  mem_req_if.requester              mem_wr
);

  hdmi_bus_pkg::reg_offset_e offset;
  hdmi_bus_pkg::mem_addr_t   fb_wr_addr;
  hdmi_bus_pkg::mem_addr_t   req_addr;
  hdmi_bus_pkg::mem_data_t   req_data;
  logic                      wr_busy;
  logic                      wr_start;

  assign offset = hdmi_bus_pkg::reg_offset_e'(lb_addr);

  // Write 1 to STATUS bit0 clears the sticky flag
  assign underflow_clr = lb_wr_en && (offset == hdmi_bus_pkg::STATUS) && lb_wr_data[0];

  // Data write while a request is pending is dropped
  assign wr_start = lb_wr_en && (offset == hdmi_bus_pkg::FB_WR_DATA) && !wr_busy;

  // Single outstanding host write
  assign mem_wr.valid = wr_busy;
  assign mem_wr.we    = 1'b1;
  assign mem_wr.addr  = req_addr;
  assign mem_wr.wdata = req_data;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      lb_wr_valid <= 1'b0;
      lb_rd_valid <= 1'b0;
      lb_rd_data  <= '0;
      fetch_en    <= 1'b0;
      drvr_en     <= 1'b0;
      fb_base     <= '0;
      fb_wr_addr  <= '0;
      wr_busy     <= 1'b0;
    end
    else
    begin
      lb_wr_valid <= lb_wr_en;
      lb_rd_valid <= lb_rd_en;
      if (lb_wr_en)
      begin
        case (offset)
          hdmi_bus_pkg::CONFIG:
          begin
            fetch_en <= lb_wr_data[0];
            drvr_en  <= lb_wr_data[1];
          end
          hdmi_bus_pkg::FB_BASE:    fb_base    <= hdmi_bus_pkg::mem_addr_t'(lb_wr_data);
          hdmi_bus_pkg::FB_WR_ADDR: fb_wr_addr <= hdmi_bus_pkg::mem_addr_t'(lb_wr_data);
          default: ;
        endcase
      end
      // Address steps as soon as the write is taken
      if (wr_start)
      begin
        wr_busy    <= 1'b1;
        fb_wr_addr <= fb_wr_addr + 1'b1;
      end
      else if (mem_wr.ready)
        wr_busy <= 1'b0;
      if (lb_rd_en)
      begin
        case (offset)
          hdmi_bus_pkg::CONFIG:     lb_rd_data <= hdmi_bus_pkg::lb_data_t'({drvr_en, fetch_en});
          hdmi_bus_pkg::STATUS:     lb_rd_data <= hdmi_bus_pkg::lb_data_t'({wr_busy, underflow});
          hdmi_bus_pkg::FIFO_OCC:   lb_rd_data <= hdmi_bus_pkg::lb_data_t'(fifo_count);
          hdmi_bus_pkg::FB_BASE:    lb_rd_data <= hdmi_bus_pkg::lb_data_t'(fb_base);
          hdmi_bus_pkg::FB_WR_ADDR: lb_rd_data <= hdmi_bus_pkg::lb_data_t'(fb_wr_addr);
          // Write only
          hdmi_bus_pkg::FB_WR_DATA: lb_rd_data <= '0;
          default:                  lb_rd_data <= `HDMI_UNMAPPED_RD_VAL;
        endcase
      end
    end
  end

  // Request payload
  always_ff @(posedge clk)
  begin
    if (wr_start)
    begin
      req_addr <= fb_wr_addr;
      req_data <= hdmi_bus_pkg::mem_data_t'(lb_wr_data);
    end
  end

  // Host issues one access per cycle
  a_lb_excl: assert property (@(posedge clk) disable iff (!rst_n) !(lb_wr_en && lb_rd_en));

endmodule

`default_nettype wire

// ==== hdl/mem_arbiter.sv ====
`default_nettype none
`timescale 1ns/100ps

module mem_arbiter (
  input  logic                    clk,
  input  logic                    rst_n,
  mem_req_if.arbiter              host,
  mem_req_if.arbiter              fetch,
  output logic                    mem_req_valid,
  input  logic                    mem_req_ready,
  output logic                    mem_req_we,
  output hdmi_bus_pkg::mem_addr_t mem_req_addr,
  output hdmi_bus_pkg::mem_data_t mem_req_wdata
);

  // High when the fetcher wins a tie
  logic prio_fetch;
  logic grant_host;
  logic grant_fetch;

  assign grant_host  = host.valid && (!fetch.valid || !prio_fetch);
  assign grant_fetch = fetch.valid && (!host.valid || prio_fetch);

  // Request mux
  assign mem_req_valid = host.valid || fetch.valid;
  assign mem_req_we    = grant_host ? host.we    : fetch.we;
  assign mem_req_addr  = grant_host ? host.addr  : fetch.addr;
  assign mem_req_wdata = grant_host ? host.wdata : fetch.wdata;

  assign host.ready  = grant_host && mem_req_ready;
  assign fetch.ready = grant_fetch && mem_req_ready;

  // Stalled grant keeps priority, a transfer hands it to the other side
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      prio_fetch <= 1'b0;
    else if (mem_req_valid)
      prio_fetch <= mem_req_ready ? grant_host : grant_fetch;
  end

  a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
    !(grant_host && grant_fetch));

  // Stalled grant stays put while the requester holds its request
  a_grant_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (grant_host && !mem_req_ready) |=> grant_host);

endmodule

`default_nettype wire

// ==== hdl/frame_fetch.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "hdmi_defines.svh"

module frame_fetch (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      fetch_en,
  input  hdmi_bus_pkg::mem_addr_t   fb_base,
  mem_req_if.requester              mem_rd,
  input  logic                      mem_rsp_valid,
  input  hdmi_bus_pkg::mem_data_t   mem_rsp_data,
  input  hdmi_video_pkg::fifo_cnt_t fifo_count,
  output logic                      push,
  output hdmi_video_pkg::pixel_t    push_data
);

  localparam int unsigned FRAME_WORDS = `HDMI_H_ACTIVE * `HDMI_V_ACTIVE;
  localparam int unsigned OFS_W = $clog2(FRAME_WORDS);

  logic [OFS_W-1:0]          ofs;
  hdmi_bus_pkg::mem_addr_t   frame_base;
  // Counted from issue to response, pending request included
  hdmi_video_pkg::fifo_cnt_t in_flight;
  logic                      req_valid;
  logic                      has_credit;
  logic                      issue;
  logic                      xfer;
  logic                      last_word;

  assign xfer       = req_valid && mem_rd.ready;
  assign last_word  = ofs == OFS_W'(FRAME_WORDS - 1);
  assign has_credit = (32'(fifo_count) + 32'(in_flight)) < `HDMI_FIFO_DEPTH;
  assign issue      = fetch_en && has_credit && (!req_valid || mem_rd.ready);

  // Reads only
  assign mem_rd.valid = req_valid;
  assign mem_rd.we    = 1'b0;
  assign mem_rd.addr  = frame_base + hdmi_bus_pkg::mem_addr_t'(ofs);
  assign mem_rd.wdata = '0;

  // Responses land in the FIFO as they arrive
  assign push      = mem_rsp_valid;
  assign push_data = hdmi_video_pkg::pixel_t'(mem_rsp_data);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      req_valid  <= 1'b0;
      ofs        <= '0;
      frame_base <= '0;
      in_flight  <= '0;
    end
    else
    begin
      if (issue)
        req_valid <= 1'b1;
      else if (xfer)
        req_valid <= 1'b0;
      if (xfer)
        ofs <= last_word ? '0 : ofs + 1'b1;
      // New base taken only at a frame boundary
      if ((xfer && last_word) || (ofs == '0 && !req_valid))
        frame_base <= fb_base;
      in_flight <= in_flight + hdmi_video_pkg::fifo_cnt_t'(issue)
                   - hdmi_video_pkg::fifo_cnt_t'(mem_rsp_valid);
    end
  end

  a_no_full_push: assert property (@(posedge clk) disable iff (!rst_n)
    push |-> (32'(fifo_count) < `HDMI_FIFO_DEPTH));

  a_rsp_expected: assert property (@(posedge clk) disable iff (!rst_n)
    mem_rsp_valid |-> (in_flight != '0));

endmodule

`default_nettype wire

// ==== hdl/pixel_fifo.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "hdmi_defines.svh"

module pixel_fifo (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      push,
  input  hdmi_video_pkg::pixel_t    push_data,
  input  logic                      pop,
  output hdmi_video_pkg::pixel_t    pop_data,
  output hdmi_video_pkg::fifo_cnt_t count,
  output logic                      underflow,
  input  logic                      underflow_clr
);

  localparam int unsigned DEPTH = `HDMI_FIFO_DEPTH;
  localparam int unsigned PTR_W = $clog2(DEPTH);

  hdmi_video_pkg::pixel_t mem [DEPTH];
  logic [PTR_W-1:0]       wr_ptr;
  logic [PTR_W-1:0]       rd_ptr;
  logic                   empty;
  logic                   do_push;
  logic                   do_pop;

  assign empty   = count == '0;
  assign do_push = push && (32'(count) < DEPTH);
  assign do_pop  = pop && !empty;

  // Head word is visible without a read cycle, zero when empty
  assign pop_data = empty ? '0 : mem[rd_ptr];

  always_ff @(posedge clk)
  begin
    if (do_push)
      mem[wr_ptr] <= push_data;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      underflow <= 1'b0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= (32'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (32'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
      // Set beats clear in the same cycle
      if (pop && empty)
        underflow <= 1'b1;
      else if (underflow_clr)
        underflow <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/video_timing_gen.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "hdmi_defines.svh"

module video_timing_gen (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   drvr_en,
  output logic                   pop,
  input  hdmi_video_pkg::pixel_t pop_data,
  output hdmi_video_pkg::pixel_t tx_d,
  output logic                   tx_de,
  output logic                   tx_hs,
  output logic                   tx_vs
);

  localparam logic SYNC_ON = 1'(`HDMI_SYNC_ACTIVE_HIGH);

  hdmi_video_pkg::timing_phase_e h_phase;
  hdmi_video_pkg::timing_phase_e v_phase;
  hdmi_video_pkg::h_cnt_t        h_cnt;
  hdmi_video_pkg::v_cnt_t        v_cnt;
  logic                          running;
  logic                          h_last;
  logic                          v_last;

  // Last count of each horizontal phase
  function automatic hdmi_video_pkg::h_cnt_t h_end(input hdmi_video_pkg::timing_phase_e p);
    case (p)
      hdmi_video_pkg::ACTIVE: return hdmi_video_pkg::h_cnt_t'(`HDMI_H_ACTIVE - 1);
      hdmi_video_pkg::FRONT:  return hdmi_video_pkg::h_cnt_t'(`HDMI_H_FP - 1);
      hdmi_video_pkg::SYNC:   return hdmi_video_pkg::h_cnt_t'(`HDMI_H_SYNC - 1);
      default:                return hdmi_video_pkg::h_cnt_t'(`HDMI_H_BP - 1);
    endcase
  endfunction

  // Same in lines
  function automatic hdmi_video_pkg::v_cnt_t v_end(input hdmi_video_pkg::timing_phase_e p);
    case (p)
      hdmi_video_pkg::ACTIVE: return hdmi_video_pkg::v_cnt_t'(`HDMI_V_ACTIVE - 1);
      hdmi_video_pkg::FRONT:  return hdmi_video_pkg::v_cnt_t'(`HDMI_V_FP - 1);
      hdmi_video_pkg::SYNC:   return hdmi_video_pkg::v_cnt_t'(`HDMI_V_SYNC - 1);
      default:                return hdmi_video_pkg::v_cnt_t'(`HDMI_V_BP - 1);
    endcase
  endfunction

  // ACTIVE, FRONT, SYNC, BACK, round again
  function automatic hdmi_video_pkg::timing_phase_e next_phase(
    input hdmi_video_pkg::timing_phase_e p
  );
    case (p)
      hdmi_video_pkg::ACTIVE: return hdmi_video_pkg::FRONT;
      hdmi_video_pkg::FRONT:  return hdmi_video_pkg::SYNC;
      hdmi_video_pkg::SYNC:   return hdmi_video_pkg::BACK;
      default:                return hdmi_video_pkg::ACTIVE;
    endcase
  endfunction

  assign h_last = h_cnt == h_end(h_phase);
  assign v_last = v_cnt == v_end(v_phase);
  assign pop    = running && (h_phase == hdmi_video_pkg::ACTIVE)
                  && (v_phase == hdmi_video_pkg::ACTIVE);

  // Idle parks both FSMs on the first active pixel
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      running <= 1'b0;
      h_phase <= hdmi_video_pkg::ACTIVE;
      v_phase <= hdmi_video_pkg::ACTIVE;
      h_cnt   <= '0;
      v_cnt   <= '0;
    end
    else if (!running)
      running <= drvr_en;
    else if (!h_last)
      h_cnt <= h_cnt + 1'b1;
    else
    begin
      h_cnt   <= '0;
      h_phase <= next_phase(h_phase);
      // End of line steps the vertical FSM
      if (h_phase == hdmi_video_pkg::BACK)
      begin
        if (!v_last)
          v_cnt <= v_cnt + 1'b1;
        else
        begin
          v_cnt   <= '0;
          v_phase <= next_phase(v_phase);
          // Frame done, stop here if the driver was disabled
          if (v_phase == hdmi_video_pkg::BACK)
            running <= drvr_en;
        end
      end
    end
  end

  // Output stage to the transmitter pins
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx_d  <= '0;
      tx_de <= 1'b0;
      tx_hs <= ~SYNC_ON;
      tx_vs <= ~SYNC_ON;
    end
    else
    begin
      tx_de <= pop;
      tx_d  <= pop ? pop_data : '0;
      tx_hs <= (running && h_phase == hdmi_video_pkg::SYNC) ? SYNC_ON : ~SYNC_ON;
      tx_vs <= (running && v_phase == hdmi_video_pkg::SYNC) ? SYNC_ON : ~SYNC_ON;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/hdmi_cntrlr.sv ====
`default_nettype none
`timescale 1ns/100ps

module hdmi_cntrlr (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    lb_wr_en,
  input  logic                    lb_rd_en,
  input  hdmi_bus_pkg::lb_addr_t  lb_addr,
  input  hdmi_bus_pkg::lb_data_t  lb_wr_data,
  output logic                    lb_wr_valid,
  output logic                    lb_rd_valid,
  output hdmi_bus_pkg::lb_data_t  lb_rd_data,
  output logic                    mem_req_valid,
  input  logic                    mem_req_ready,
  output logic                    mem_req_we,
  output hdmi_bus_pkg::mem_addr_t mem_req_addr,
  output hdmi_bus_pkg::mem_data_t mem_req_wdata,
  input  logic                    mem_rsp_valid,
  input  hdmi_bus_pkg::mem_data_t mem_rsp_data,
  output hdmi_video_pkg::pixel_t  tx_d,
  output logic                    tx_de,
  output logic                    tx_hs,
  output logic                    tx_vs
);

  hdmi_video_pkg::fifo_cnt_t fifo_count;
  hdmi_video_pkg::pixel_t    push_data;
  hdmi_video_pkg::pixel_t    pop_data;
  hdmi_bus_pkg::mem_addr_t   fb_base;
  logic                      fetch_en;
  logic                      drvr_en;
  logic                      push;
  logic                      pop;
  logic                      underflow;
  logic                      underflow_clr;

  // Host writes and frame reads share the memory port
  mem_req_if host_req ();
  mem_req_if fetch_req ();

  hdmi_regfile i_regfile (
    .clk, .rst_n, .lb_wr_en, .lb_rd_en, .lb_addr, .lb_wr_data,
    .lb_wr_valid, .lb_rd_valid, .lb_rd_data, .fifo_count,
    .underflow, .underflow_clr, .fetch_en, .drvr_en, .fb_base,
    .mem_wr (host_req.requester)
  );

  mem_arbiter i_arbiter (
    .clk, .rst_n,
    .host  (host_req.arbiter),
    .fetch (fetch_req.arbiter),
    .mem_req_valid, .mem_req_ready, .mem_req_we, .mem_req_addr, .mem_req_wdata
  );

  frame_fetch i_fetch (
    .clk, .rst_n, .fetch_en, .fb_base,
    .mem_rd (fetch_req.requester),
    .mem_rsp_valid, .mem_rsp_data, .fifo_count, .push, .push_data
  );

  pixel_fifo i_fifo (
    .clk, .rst_n, .push, .push_data, .pop, .pop_data,
    .count (fifo_count), .underflow, .underflow_clr
  );

  video_timing_gen i_timing (
    .clk, .rst_n, .drvr_en, .pop, .pop_data, .tx_d, .tx_de, .tx_hs, .tx_vs
  );

endmodule

`default_nettype wire

// ==== dv/hdmi_cntrlr_tb.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "hdmi_defines.svh"

module hdmi_cntrlr_tb;

  localparam int CLK_NS = 4;
  localparam int MEM_WORDS = 1024;
  localparam int LINE = `HDMI_H_ACTIVE + `HDMI_H_FP + `HDMI_H_SYNC + `HDMI_H_BP;
  localparam int FRAME_CYC = LINE * (`HDMI_V_ACTIVE + `HDMI_V_FP + `HDMI_V_SYNC + `HDMI_V_BP);
  localparam logic SYNC_ON = 1'(`HDMI_SYNC_ACTIVE_HIGH);

  logic clk;
  logic rst_n;
  logic lb_wr_en;
  logic lb_rd_en;
  hdmi_bus_pkg::lb_addr_t lb_addr;
  hdmi_bus_pkg::lb_data_t lb_wr_data;
  logic lb_wr_valid;
  logic lb_rd_valid;
  hdmi_bus_pkg::lb_data_t lb_rd_data;
  logic mem_req_valid;
  logic mem_req_ready;
  logic mem_req_we;
  hdmi_bus_pkg::mem_addr_t mem_req_addr;
  hdmi_bus_pkg::mem_data_t mem_req_wdata;
  logic mem_rsp_valid;
  hdmi_bus_pkg::mem_data_t mem_rsp_data;
  hdmi_video_pkg::pixel_t tx_d;
  logic tx_de;
  logic tx_hs;
  logic tx_vs;

  integer seed;
  // Memory model and the expected frame buffer contents
  logic [31:0] mem_model [MEM_WORDS];
  logic [31:0] ref_mem [MEM_WORDS];
  logic [31:0] exp_wr_addr [$];
  logic [31:0] exp_wr_data [$];
  logic [31:0] rsp_data_q [$];
  int rsp_due_q [$];
  int cyc = 0;
  int last_due = 0;
  int idle_cnt = 0;
  // Parsed commands
  byte op_q [$];
  logic [31:0] a1_q [$];
  logic [31:0] a2_q [$];
  int err_cnt = 0;
  bit loaded = 0;
  longint budget_ns = 0;
  logic [31:0] ref_ptr = 0;

  hdmi_cntrlr i_hdmi_cntrlr (.*);

  initial
  begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  function automatic logic [31:0] fill_word(input logic [31:0] a);
    return {~a[7:0], a[15:0] ^ 16'h5a5a, a[7:0]};
  endfunction

  task automatic fail_now(input string msg);
    err_cnt++;
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "stopping at first error");
  endtask

  // Memory port, one response per cycle, in request order
  always @(negedge clk)
  begin
    int lat;
    int due;
    cyc = cyc + 1;
    mem_rsp_valid = 1'b0;
    mem_rsp_data = '0;
    if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cyc)
    begin
      mem_rsp_valid = 1'b1;
      mem_rsp_data = rsp_data_q.pop_front();
      void'(rsp_due_q.pop_front());
    end
    mem_req_ready = rst_n && (($random(seed) & 3) != 0);
    if (mem_req_valid && mem_req_ready)
    begin
      assert (32'(mem_req_addr) < MEM_WORDS)
      else fail_now("memory request outside the modeled range");
      if (mem_req_we)
      begin
        assert (exp_wr_addr.size() > 0) else fail_now("memory write that the host never issued");
        assert (32'(mem_req_addr) == exp_wr_addr[0])
        else fail_now($sformatf("mismatch mem_req_addr: got %h expected %h",
                                mem_req_addr, exp_wr_addr[0]));
        assert (mem_req_wdata == exp_wr_data[0])
        else fail_now($sformatf("mismatch mem_req_wdata: got %h expected %h",
                                mem_req_wdata, exp_wr_data[0]));
        mem_model[mem_req_addr[9:0]] = mem_req_wdata;
        void'(exp_wr_addr.pop_front());
        void'(exp_wr_data.pop_front());
      end
      else
      begin
        lat = 1 + ($random(seed) & 3);
        due = cyc + lat;
        if (due <= last_due)
          due = last_due + 1;
        last_due = due;
        rsp_due_q.push_back(due);
        rsp_data_q.push_back(mem_model[mem_req_addr[9:0]]);
      end
    end
  end

  // Blank cycles since the last DE, used to find a frame start
  always @(negedge clk)
    idle_cnt <= tx_de ? 0 : ((idle_cnt < 1000) ? idle_cnt + 1 : idle_cnt);

  task automatic reg_write(input logic [31:0] a, input logic [31:0] d);
    @(negedge clk);
    lb_addr = 8'(a);
    lb_wr_data = d;
    lb_wr_en = 1'b1;
    @(negedge clk);
    lb_wr_en = 1'b0;
    assert (lb_wr_valid) else fail_now("lb_wr_valid missing one cycle after the write");
  endtask

  task automatic reg_read(input logic [31:0] a, output logic [31:0] d);
    @(negedge clk);
    lb_addr = 8'(a);
    lb_rd_en = 1'b1;
    @(negedge clk);
    lb_rd_en = 1'b0;
    assert (lb_rd_valid) else fail_now("lb_rd_valid missing one cycle after the read");
    d = lb_rd_data;
  endtask

  // One frame is active lines plus vertical blanking, starting at the first DE
  task automatic capture_frames(input int n, input logic [31:0] base, input bit zero);
    int line;
    int col;
    bit exp_de;
    logic exp_hs;
    logic exp_vs;
    hdmi_video_pkg::pixel_t exp_pix;
    for (int f = 0; f < n; f++)
    begin
      do
        @(negedge clk);
      while (!(tx_de && idle_cnt >= 20));
      for (int c = 0; c < FRAME_CYC; c++)
      begin
        if (c > 0)
          @(negedge clk);
        line = c / LINE;
        col = c % LINE;
        exp_de = line < `HDMI_V_ACTIVE && col < `HDMI_H_ACTIVE;
        exp_hs = (col >= `HDMI_H_ACTIVE + `HDMI_H_FP
                  && col < `HDMI_H_ACTIVE + `HDMI_H_FP + `HDMI_H_SYNC) ? SYNC_ON : ~SYNC_ON;
        exp_vs = (line >= `HDMI_V_ACTIVE + `HDMI_V_FP
                  && line < `HDMI_V_ACTIVE + `HDMI_V_FP + `HDMI_V_SYNC) ? SYNC_ON : ~SYNC_ON;
        exp_pix = '0;
        if (exp_de && !zero)
          exp_pix = ref_mem[10'(base + 32'(line * `HDMI_H_ACTIVE + col))][23:0];
        assert (tx_de == exp_de)
        else fail_now($sformatf("mismatch tx_de: got %h expected %h", tx_de, exp_de));
        assert (tx_hs == exp_hs)
        else fail_now($sformatf("mismatch tx_hs: got %h expected %h", tx_hs, exp_hs));
        assert (tx_vs == exp_vs)
        else fail_now($sformatf("mismatch tx_vs: got %h expected %h", tx_vs, exp_vs));
        assert (tx_d == exp_pix)
        else fail_now($sformatf("mismatch tx_d: got %h expected %h", tx_d, exp_pix));
      end
    end
  endtask

  task automatic load_commands();
    int fd;
    int code;
    string tok;
    string rest;
    logic [31:0] x;
    logic [31:0] y;
    longint cycles;
    fd = $fopen("dv/hdmi_input.txt", "r");
    if (fd == 0)
      fail_now("cannot open dv/hdmi_input.txt");
    cycles = 0;
    while (!$feof(fd))
    begin
      code = $fscanf(fd, "%s", tok);
      if (code != 1)
        break;
      x = '0;
      y = '0;
      if (tok.getc(0) == "#")
      begin
        code = $fgets(rest, fd);
        continue;
      end
      if (tok == "W" || tok == "R" || tok == "F")
        code = $fscanf(fd, "%h %h", x, y);
      else if (tok == "D" || tok == "Z")
        code = $fscanf(fd, "%h", x);
      else if (tok != "P" && tok != "E")
        fail_now({"unknown command in data file: ", tok});
      if (tok == "E")
        break;
      op_q.push_back(byte'(tok.getc(0)));
      a1_q.push_back(x);
      a2_q.push_back(y);
      cycles += 40;
      if (tok == "F" || tok == "Z")
        cycles += longint'(x + 2) * FRAME_CYC;
      if (tok == "D")
        cycles += longint'(x);
    end
    $fclose(fd);
    budget_ns = cycles * CLK_NS * 2;
    loaded = 1;
  endtask

  // Watchdog
  initial
  begin
    wait (loaded);
    #(budget_ns);
    $display("Timeout after %0d ns, the command list did not finish", budget_ns);
    $display("Result: FAILED");
    $fatal(1, "watchdog expired");
  end

  initial
  begin
    logic [31:0] v;
    seed = 32'hfef9e835;
    rst_n = 1'b0;
    lb_wr_en = 1'b0;
    lb_rd_en = 1'b0;
    lb_addr = '0;
    lb_wr_data = '0;
    mem_req_ready = 1'b0;
    mem_rsp_valid = 1'b0;
    mem_rsp_data = '0;
    for (int i = 0; i < MEM_WORDS; i++)
    begin
      mem_model[10'(i)] = fill_word(32'(i));
      ref_mem[10'(i)] = fill_word(32'(i));
    end
    load_commands();
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    assert (!tx_de && tx_hs == ~SYNC_ON && tx_vs == ~SYNC_ON && tx_d == '0)
    else fail_now("tx outputs not idle after reset");
    for (int k = 0; k < op_q.size(); k++)
    begin
      case (op_q[k])
        "W":
        begin
          if (a1_q[k] == 32'h10)
            ref_ptr = a2_q[k];
          if (a1_q[k] == 32'h14)
          begin
            exp_wr_addr.push_back(ref_ptr);
            exp_wr_data.push_back(a2_q[k]);
            ref_mem[10'(ref_ptr)] = a2_q[k];
            ref_ptr = ref_ptr + 1;
          end
          reg_write(a1_q[k], a2_q[k]);
        end
        "R":
        begin
          reg_read(a1_q[k], v);
          assert (v == a2_q[k])
          else fail_now($sformatf("mismatch lb_rd_data at %h: got %h expected %h",
                                  a1_q[k], v, a2_q[k]));
        end
        // Wait for wr_busy to drop
        "P":
        begin
          do
            reg_read(32'h04, v);
          while (v[1]);
        end
        "D": repeat (int'(a1_q[k])) @(negedge clk);
        "F": capture_frames(int'(a1_q[k]), a2_q[k], 1'b0);
        "Z": capture_frames(int'(a1_q[k]), '0, 1'b1);
        default: fail_now("bad command code");
      endcase
    end
    assert (exp_wr_addr.size() == 0) else fail_now("host writes never reached memory");
    if (err_cnt == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+hdl
hdl/hdmi_bus_pkg.sv
hdl/hdmi_video_pkg.sv
hdl/mem_req_if.sv
hdl/hdmi_regfile.sv
hdl/mem_arbiter.sv
hdl/frame_fetch.sv
hdl/pixel_fifo.sv
hdl/video_timing_gen.sv
hdl/hdmi_cntrlr.sv
dv/hdmi_cntrlr_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = hdmi_cntrlr_tb
FILELIST = src.f

OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
DATA     = dv/hdmi_input.txt
SRCS     = $(shell grep -v '^+' $(FILELIST)) $(wildcard hdl/*.svh)

.PHONY: all run check clean

all: check

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN) $(DATA)
	-./$(BIN) 2>&1 | tee $(LOG)

check: run
	@if grep -q "Result: FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "Result: PASSED" $(LOG) || { echo "No pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/hdmi_input.txt ====
# Op arg1 arg2, all numbers hex
# W addr data, R addr expected, P, D cycles, Z frames, F frames base, E
R 00 0
R 04 0
R 08 0
R 0c 0
R 10 0
R 18 deadbabe
W 00 2
R 00 2
R 04 1
Z 1
W 00 0
D 78
W 04 1
R 04 0
W 10 40
W 14 00a1b2c3
P
W 14 00d4e5f6
P
W 14 ff102030
P
W 14 00405060
P
R 10 44
W 0c 40
W 00 1
D 40
R 08 10
R 04 0
W 00 3
F 2 40
W 0c 80
F 1 80
R 0c 80
E
